//--- csr_pkg.sv
package csr_pkg;

    localparam int CSR_ADDR_W = 14;
    localparam int XLEN       = 32;
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;
    localparam int HWI_W      = 8;
    localparam int IS_W       = 13;  // interrupt status / enable field
    localparam int TI_BIT     = 11;

    // estat code field positions
    localparam int ECODE_LSB    = 16;
    localparam int ESUBCODE_LSB = 22;

    // ecode left behind by a tlb refill, checked on ertn
    localparam logic [ECODE_W-1:0] ECODE_TLBR = 6'h3f;

    localparam logic [XLEN-1:0] CRMD_RESET = 32'h0000_0008;  // da set

    localparam logic [XLEN-1:0] CRMD_WMASK   = 32'h0000_01ff;
    localparam logic [XLEN-1:0] PRMD_WMASK   = 32'h0000_0007;
    localparam logic [XLEN-1:0] ECFG_WMASK   = 32'h0000_1bff;  // bit 10 reserved
    localparam logic [XLEN-1:0] ESTAT_WMASK  = 32'h0000_0003;  // software irq bits only
    localparam logic [XLEN-1:0] EENTRY_WMASK = 32'hffff_ffc0;

    typedef enum logic [CSR_ADDR_W-1:0] {
        CRMD   = 14'h000,
        PRMD   = 14'h001,
        ECFG   = 14'h004,
        ESTAT  = 14'h005,
        ERA    = 14'h006,
        BADV   = 14'h007,
        EENTRY = 14'h00c,
        SAVE0  = 14'h030,
        SAVE1  = 14'h031,
        SAVE2  = 14'h032,
        SAVE3  = 14'h033,
        TID    = 14'h040,
        TCFG   = 14'h041,
        TVAL   = 14'h042,
        TICLR  = 14'h044
    } csr_addr_e;

    // exception causes from the pipeline controller
    typedef enum logic [6:0] {
        INT  = 7'h00,
        PIL  = 7'h01,
        PIS  = 7'h02,
        PIF  = 7'h03,
        PME  = 7'h04,
        PPI  = 7'h07,
        ADEF = 7'h08,
        ALE  = 7'h09,
        SYS  = 7'h0b,
        BRK  = 7'h0c,
        TLBR = 7'h3f
    } exc_cause_e;

endpackage

//--- csr_trap_unit.sv
`timescale 1ns/1ps

module csr_trap_unit import csr_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  csr_we_i,
    input  csr_addr_e             csr_waddr_i,
    input  logic [XLEN-1:0]       csr_wdata_i,

    input  logic                  exc_valid_i,
    input  exc_cause_e            exc_cause_i,
    input  logic [XLEN-1:0]       exc_pc_i,
    input  logic [XLEN-1:0]       exc_addr_i,
    input  logic [ECODE_W-1:0]    exc_ecode_i,
    input  logic [ESUBCODE_W-1:0] exc_esubcode_i,
    input  logic                  exc_inst_i,
    input  logic                  ertn_i,

    input  logic [HWI_W-1:0]      hwi_i,
    input  logic                  ti_i,

    output logic [XLEN-1:0]       crmd_o,
    output logic [XLEN-1:0]       prmd_o,
    output logic [XLEN-1:0]       ecfg_o,
    output logic [XLEN-1:0]       estat_o,
    output logic [XLEN-1:0]       era_o,
    output logic [XLEN-1:0]       badv_o,
    output logic [XLEN-1:0]       eentry_o,
    output logic                  irq_o
);

    logic [XLEN-1:0] crmd_q;
    logic [XLEN-1:0] prmd_q;
    logic [XLEN-1:0] ecfg_q;
    logic [XLEN-1:0] estat_q;  // everything except the timer bit
    logic [XLEN-1:0] era_q;
    logic [XLEN-1:0] badv_q;
    logic [XLEN-1:0] eentry_q;

    logic            badv_upd;
    logic [XLEN-1:0] badv_nxt;
    logic            ertn_tlbr;

    wire crmd_we   = csr_we_i && (csr_waddr_i == CRMD);
    wire prmd_we   = csr_we_i && (csr_waddr_i == PRMD);
    wire ecfg_we   = csr_we_i && (csr_waddr_i == ECFG);
    wire estat_we  = csr_we_i && (csr_waddr_i == ESTAT);
    wire era_we    = csr_we_i && (csr_waddr_i == ERA);
    wire badv_we   = csr_we_i && (csr_waddr_i == BADV);
    wire eentry_we = csr_we_i && (csr_waddr_i == EENTRY);

    assign ertn_tlbr = (estat_q[ECODE_LSB +: ECODE_W] == ECODE_TLBR);

    // bad address source per cause
    always_comb begin
        badv_upd = 1'b0;
        badv_nxt = exc_addr_i;
        case (exc_cause_i)
            TLBR, ALE, PIL, PIS, PIF, PME, PPI: begin
                badv_upd = 1'b1;
                badv_nxt = exc_inst_i ? exc_pc_i : exc_addr_i;
            end
            ADEF: begin
                badv_upd = 1'b1;
                badv_nxt = exc_pc_i;
            end
            default: begin
                badv_upd = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_q <= CRMD_RESET;
        end else if (exc_valid_i) begin
            crmd_q[2:0] <= 3'b000;  // plv 0, ie off
            if (exc_cause_i == TLBR) begin
                crmd_q[3] <= 1'b1;  // da
                crmd_q[4] <= 1'b0;  // pg
            end
        end else if (ertn_i) begin
            crmd_q[2:0] <= prmd_q[2:0];
            if (ertn_tlbr) begin
                crmd_q[3] <= 1'b0;
                crmd_q[4] <= 1'b1;
            end
        end else if (crmd_we) begin
            crmd_q <= csr_wdata_i & CRMD_WMASK;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_q <= '0;
        end else if (exc_valid_i) begin
            prmd_q[2:0] <= crmd_q[2:0];  // pplv, pie
        end else if (prmd_we) begin
            prmd_q <= csr_wdata_i & PRMD_WMASK;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ecfg_q   <= '0;
            eentry_q <= '0;
        end else begin
            if (ecfg_we) begin
                ecfg_q <= csr_wdata_i & ECFG_WMASK;
            end
            if (eentry_we) begin
                eentry_q <= csr_wdata_i & EENTRY_WMASK;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            estat_q <= '0;
        end else begin
            if (exc_valid_i) begin
                estat_q[ECODE_LSB +: ECODE_W]       <= exc_ecode_i;
                estat_q[ESUBCODE_LSB +: ESUBCODE_W] <= exc_esubcode_i;
            end else if (estat_we) begin
                estat_q <= (estat_q & ~ESTAT_WMASK) | (csr_wdata_i & ESTAT_WMASK);
            end
            estat_q[2 +: HWI_W] <= hwi_i;  // sampled every cycle
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            era_q <= '0;
        end else if (exc_valid_i) begin
            era_q <= exc_pc_i;
        end else if (era_we) begin
            era_q <= csr_wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            badv_q <= '0;
        end else if (exc_valid_i) begin
            if (badv_upd) begin
                badv_q <= badv_nxt;
            end
        end else if (badv_we) begin
            badv_q <= csr_wdata_i;
        end
    end

    // timer bit lives in csr_timer
    always_comb begin
        estat_o         = estat_q;
        estat_o[TI_BIT] = ti_i;
    end

    assign crmd_o   = crmd_q;
    assign prmd_o   = prmd_q;
    assign ecfg_o   = ecfg_q;
    assign era_o    = era_q;
    assign badv_o   = badv_q;
    assign eentry_o = eentry_q;

    assign irq_o = ((ecfg_q[IS_W-1:0] & estat_o[IS_W-1:0]) != '0) && crmd_q[2];

endmodule

//--- csr_timer.sv
`timescale 1ns/1ps

module csr_timer import csr_pkg::*; (
    input  logic            clk,
    input  logic            rst,

    input  logic            csr_we_i,
    input  csr_addr_e       csr_waddr_i,
    input  logic [XLEN-1:0] csr_wdata_i,

    output logic [XLEN-1:0] tid_o,
    output logic [XLEN-1:0] tcfg_o,
    output logic [XLEN-1:0] tval_o,
    output logic            ti_o
);

    logic [XLEN-1:0] tid_q;
    logic [XLEN-1:0] tcfg_q;
    logic [XLEN-1:0] tval_q;
    logic            timer_en;
    logic            ti_q;
    logic            expire;

    wire tid_we   = csr_we_i && (csr_waddr_i == TID);
    wire tcfg_we  = csr_we_i && (csr_waddr_i == TCFG);
    wire ticlr_we = csr_we_i && (csr_waddr_i == TICLR);

    // a fresh tcfg write wins over expiry
    assign expire = timer_en && (tval_q == '0) && !tcfg_we;

    always_ff @(posedge clk) begin
        if (rst) begin
            tid_q    <= '0;
            tcfg_q   <= '0;
            tval_q   <= '0;
            timer_en <= 1'b0;
        end else begin
            if (tid_we) begin
                tid_q <= csr_wdata_i;
            end
            if (tcfg_we) begin
                tcfg_q   <= csr_wdata_i;
                tval_q   <= {csr_wdata_i[XLEN-1:2], 2'b00};
                timer_en <= csr_wdata_i[0];
            end else if (expire) begin
                tval_q   <= tcfg_q[1] ? {tcfg_q[XLEN-1:2], 2'b00} : '1;  // periodic reload
                timer_en <= tcfg_q[1];
            end else if (timer_en) begin
                tval_q <= tval_q - XLEN'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ti_q <= 1'b0;
        end else if (ticlr_we && csr_wdata_i[0]) begin
            ti_q <= 1'b0;  // clear beats set
        end else if (expire) begin
            ti_q <= 1'b1;
        end
    end

    assign tid_o  = tid_q;
    assign tcfg_o = tcfg_q;
    assign tval_o = tval_q;
    assign ti_o   = ti_q;

endmodule

//--- csr_save_bank.sv
`timescale 1ns/1ps

module csr_save_bank import csr_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            csr_we_i,
    input  csr_addr_e       csr_waddr_i,
    input  logic [XLEN-1:0] csr_wdata_i,
    output logic [XLEN-1:0] save0_o,
    output logic [XLEN-1:0] save1_o,
    output logic [XLEN-1:0] save2_o,
    output logic [XLEN-1:0] save3_o
);

    logic [XLEN-1:0] save_q [4];
    logic [3:0]      save_we;

    assign save_we[0] = csr_we_i && (csr_waddr_i == SAVE0);
    assign save_we[1] = csr_we_i && (csr_waddr_i == SAVE1);
    assign save_we[2] = csr_we_i && (csr_waddr_i == SAVE2);
    assign save_we[3] = csr_we_i && (csr_waddr_i == SAVE3);

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (rst) begin
                save_q[i] <= '0;
            end else if (save_we[i]) begin
                save_q[i] <= csr_wdata_i;  // full width
            end
        end
    end

    assign save0_o = save_q[0];
    assign save1_o = save_q[1];
    assign save2_o = save_q[2];
    assign save3_o = save_q[3];

endmodule

//--- csr_read_mux.sv
`timescale 1ns/1ps

module csr_read_mux import csr_pkg::*; (
    input  logic                  rd1_en_i,
    input  logic [CSR_ADDR_W-1:0] rd1_addr_i,
    input  logic                  rd2_en_i,
    input  logic [CSR_ADDR_W-1:0] rd2_addr_i,

    input  logic [XLEN-1:0]       crmd_i,
    input  logic [XLEN-1:0]       prmd_i,
    input  logic [XLEN-1:0]       ecfg_i,
    input  logic [XLEN-1:0]       estat_i,
    input  logic [XLEN-1:0]       era_i,
    input  logic [XLEN-1:0]       badv_i,
    input  logic [XLEN-1:0]       eentry_i,
    input  logic [XLEN-1:0]       save0_i,
    input  logic [XLEN-1:0]       save1_i,
    input  logic [XLEN-1:0]       save2_i,
    input  logic [XLEN-1:0]       save3_i,
    input  logic [XLEN-1:0]       tid_i,
    input  logic [XLEN-1:0]       tcfg_i,
    input  logic [XLEN-1:0]       tval_i,

    output logic [XLEN-1:0]       rd1_data_o,
    output logic [XLEN-1:0]       rd2_data_o
);

    // one port's worth of decode, shared by both ports
    function automatic logic [XLEN-1:0] csr_select(input logic en,
                                                   input logic [CSR_ADDR_W-1:0] addr);
        logic [XLEN-1:0] data;
        data = '0;
        if (en) begin
            case (addr)
                CRMD:    data = crmd_i;
                PRMD:    data = prmd_i;
                ECFG:    data = ecfg_i;
                ESTAT:   data = estat_i;
                ERA:     data = era_i;
                BADV:    data = badv_i;
                EENTRY:  data = eentry_i;
                SAVE0:   data = save0_i;
                SAVE1:   data = save1_i;
                SAVE2:   data = save2_i;
                SAVE3:   data = save3_i;
                TID:     data = tid_i;
                TCFG:    data = tcfg_i;
                TVAL:    data = tval_i;
                default: data = '0;  // ticlr and unmapped
            endcase
        end
        return data;
    endfunction

    always_comb begin
        rd1_data_o = csr_select(rd1_en_i, rd1_addr_i);
        rd2_data_o = csr_select(rd2_en_i, rd2_addr_i);
    end

endmodule

//--- csr_top.sv
`timescale 1ns/1ps

module csr_top import csr_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  csr_we_i,
    input  csr_addr_e             csr_waddr_i,
    input  logic [XLEN-1:0]       csr_wdata_i,

    input  logic                  rd1_en_i,
    input  logic [CSR_ADDR_W-1:0] rd1_addr_i,
    output logic [XLEN-1:0]       rd1_data_o,
    input  logic                  rd2_en_i,
    input  logic [CSR_ADDR_W-1:0] rd2_addr_i,
    output logic [XLEN-1:0]       rd2_data_o,

    input  logic                  exc_valid_i,
    input  exc_cause_e            exc_cause_i,
    input  logic [XLEN-1:0]       exc_pc_i,
    input  logic [XLEN-1:0]       exc_addr_i,
    input  logic [ECODE_W-1:0]    exc_ecode_i,
    input  logic [ESUBCODE_W-1:0] exc_esubcode_i,
    input  logic                  exc_inst_i,
    input  logic                  ertn_i,

    input  logic [HWI_W-1:0]      hwi_i,

    output logic [XLEN-1:0]       eentry_o,
    output logic [XLEN-1:0]       era_o,
    output logic [XLEN-1:0]       crmd_o,
    output logic                  irq_o
);

    logic [XLEN-1:0] prmd;
    logic [XLEN-1:0] ecfg;
    logic [XLEN-1:0] estat;
    logic [XLEN-1:0] badv;
    logic [XLEN-1:0] save0;
    logic [XLEN-1:0] save1;
    logic [XLEN-1:0] save2;
    logic [XLEN-1:0] save3;
    logic [XLEN-1:0] tid;
    logic [XLEN-1:0] tcfg;
    logic [XLEN-1:0] tval;
    logic            ti;  // timer irq level

    csr_trap_unit u_trap (
        .clk            (clk),
        .rst            (rst),
        .csr_we_i       (csr_we_i),
        .csr_waddr_i    (csr_waddr_i),
        .csr_wdata_i    (csr_wdata_i),
        .exc_valid_i    (exc_valid_i),
        .exc_cause_i    (exc_cause_i),
        .exc_pc_i       (exc_pc_i),
        .exc_addr_i     (exc_addr_i),
        .exc_ecode_i    (exc_ecode_i),
        .exc_esubcode_i (exc_esubcode_i),
        .exc_inst_i     (exc_inst_i),
        .ertn_i         (ertn_i),
        .hwi_i          (hwi_i),
        .ti_i           (ti),
        .crmd_o         (crmd_o),
        .prmd_o         (prmd),
        .ecfg_o         (ecfg),
        .estat_o        (estat),
        .era_o          (era_o),
        .badv_o         (badv),
        .eentry_o       (eentry_o),
        .irq_o          (irq_o)
    );

    csr_timer u_timer (
        .clk         (clk),
        .rst         (rst),
        .csr_we_i    (csr_we_i),
        .csr_waddr_i (csr_waddr_i),
        .csr_wdata_i (csr_wdata_i),
        .tid_o       (tid),
        .tcfg_o      (tcfg),
        .tval_o      (tval),
        .ti_o        (ti)
    );

    csr_save_bank u_save (
        .clk         (clk),
        .rst         (rst),
        .csr_we_i    (csr_we_i),
        .csr_waddr_i (csr_waddr_i),
        .csr_wdata_i (csr_wdata_i),
        .save0_o     (save0),
        .save1_o     (save1),
        .save2_o     (save2),
        .save3_o     (save3)
    );

    csr_read_mux u_rd (
        .rd1_en_i   (rd1_en_i),
        .rd1_addr_i (rd1_addr_i),
        .rd2_en_i   (rd2_en_i),
        .rd2_addr_i (rd2_addr_i),
        .crmd_i     (crmd_o),
        .prmd_i     (prmd),
        .ecfg_i     (ecfg),
        .estat_i    (estat),
        .era_i      (era_o),
        .badv_i     (badv),
        .eentry_i   (eentry_o),
        .save0_i    (save0),
        .save1_i    (save1),
        .save2_i    (save2),
        .save3_i    (save3),
        .tid_i      (tid),
        .tcfg_i     (tcfg),
        .tval_i     (tval),
        .rd1_data_o (rd1_data_o),
        .rd2_data_o (rd2_data_o)
    );

endmodule

//--- csr_top_sva.sv
`timescale 1ns/1ps

module csr_top_sva import csr_pkg::*; (
    input logic             clk,
    input logic             rst,
    input logic             exc_valid_i,
    input logic [XLEN-1:0]  exc_pc_i,
    input logic [HWI_W-1:0] hwi_i,
    input logic [XLEN-1:0]  era_i,
    input logic [XLEN-1:0]  crmd_i,
    input logic [XLEN-1:0]  ecfg_i,
    input logic [XLEN-1:0]  estat_i,
    input logic             ti_i,
    input logic             irq_i,
    input logic             rd1_en_i,
    input logic [XLEN-1:0]  rd1_data_i,
    input logic             rd2_en_i,
    input logic [XLEN-1:0]  rd2_data_i
);

    int               fail_count = 0;
    logic [HWI_W-1:0] hwi_q;  // lines as estat should hold them
    logic [IS_W-1:0]  pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            hwi_q <= '0;
        end else begin
            hwi_q <= hwi_i;
        end
    end

    // software bits, hw lines one cycle late, timer; bits 12 and 10 stay zero
    assign pending = {1'b0, ti_i, 1'b0, hwi_q, estat_i[1:0]};

    a_crmd_reset: assert property (@(posedge clk) rst |=> (crmd_i == 32'h0000_0008))
        else begin
            $error("CRMD not at its reset value after reset");
            fail_count++;
        end

    a_era_capture: assert property (@(posedge clk) disable iff (rst)
        exc_valid_i |=> (era_i == $past(exc_pc_i)))
        else begin
            $error("ERA does not hold the exception PC");
            fail_count++;
        end

    a_irq_eq: assert property (@(posedge clk) disable iff (rst)
        irq_i == (((ecfg_i[12:0] & pending) != 13'b0) && crmd_i[2]))
        else begin
            $error("irq_o disagrees with ECFG, pending lines and CRMD.IE");
            fail_count++;
        end

    a_rd1_off: assert property (@(posedge clk) disable iff (rst)
        !rd1_en_i |-> (rd1_data_i == '0))
        else begin
            $error("disabled read port 1 returns data");
            fail_count++;
        end

    a_rd2_off: assert property (@(posedge clk) disable iff (rst)
        !rd2_en_i |-> (rd2_data_i == '0))
        else begin
            $error("disabled read port 2 returns data");
            fail_count++;
        end

endmodule

bind csr_top csr_top_sva u_sva (
    .clk         (clk),
    .rst         (rst),
    .exc_valid_i (exc_valid_i),
    .exc_pc_i    (exc_pc_i),
    .hwi_i       (hwi_i),
    .era_i       (era_o),
    .crmd_i      (crmd_o),
    .ecfg_i      (ecfg),
    .estat_i     (estat),
    .ti_i        (ti),
    .irq_i       (irq_o),
    .rd1_en_i    (rd1_en_i),
    .rd1_data_i  (rd1_data_o),
    .rd2_en_i    (rd2_en_i),
    .rd2_data_i  (rd2_data_o)
);

//--- tb_csr_top.sv
`timescale 1ns/1ps

module tb_csr_top import csr_pkg::*; ();

    logic                  clk;
    logic                  rst;
    logic                  csr_we;
    csr_addr_e             csr_waddr;
    logic [XLEN-1:0]       csr_wdata;
    logic                  rd1_en;
    logic [CSR_ADDR_W-1:0] rd1_addr;
    logic [XLEN-1:0]       rd1_data;
    logic                  rd2_en;
    logic [CSR_ADDR_W-1:0] rd2_addr;
    logic [XLEN-1:0]       rd2_data;
    logic                  exc_valid;
    exc_cause_e            exc_cause;
    logic [XLEN-1:0]       exc_pc;
    logic [XLEN-1:0]       exc_addr;
    logic [ECODE_W-1:0]    exc_ecode;
    logic [ESUBCODE_W-1:0] exc_esubcode;
    logic                  exc_inst;
    logic                  ertn;
    logic [HWI_W-1:0]      hwi;
    logic [XLEN-1:0]       eentry;
    logic [XLEN-1:0]       era;
    logic [XLEN-1:0]       crmd;
    logic                  irq;

    logic [31:0] rng_state = 32'hec3c_39f7;
    string       test_name;
    int          test_fails;
    int          total_fails;
    int          tests_run;
    int          checks_run;
    csr_addr_e   reg_list [15];
    csr_addr_e   mask_addr [12];
    logic [31:0] mask_val [12];

    csr_top uut (
        .clk            (clk),
        .rst            (rst),
        .csr_we_i       (csr_we),
        .csr_waddr_i    (csr_waddr),
        .csr_wdata_i    (csr_wdata),
        .rd1_en_i       (rd1_en),
        .rd1_addr_i     (rd1_addr),
        .rd1_data_o     (rd1_data),
        .rd2_en_i       (rd2_en),
        .rd2_addr_i     (rd2_addr),
        .rd2_data_o     (rd2_data),
        .exc_valid_i    (exc_valid),
        .exc_cause_i    (exc_cause),
        .exc_pc_i       (exc_pc),
        .exc_addr_i     (exc_addr),
        .exc_ecode_i    (exc_ecode),
        .exc_esubcode_i (exc_esubcode),
        .exc_inst_i     (exc_inst),
        .ertn_i         (ertn),
        .hwi_i          (hwi),
        .eentry_o       (eentry),
        .era_o          (era),
        .crmd_o         (crmd),
        .irq_o          (irq)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;  // drive point
    endtask

    task automatic start_test(input string name);
        test_name  = name;
        test_fails = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_fails == 0) begin
            $display("test %s: pass", test_name);
        end else begin
            $display("test %s: FAIL, %0d bad checks", test_name, test_fails);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks_run++;
        assert (act === exp) else begin
            $display("** Error %s/%s: expected %h, actual %h", test_name, what, exp, act);
            test_fails++;
            total_fails++;
        end
    endtask

    task automatic check_irq(input string what, input logic exp);
        check_value(what, {31'b0, exp}, {31'b0, irq});
    endtask

    task automatic write_csr(input csr_addr_e addr, input logic [31:0] data);
        csr_we    = 1'b1;
        csr_waddr = addr;
        csr_wdata = data;
        tick();
        csr_we    = 1'b0;
    endtask

    // sample both ports mid cycle, then move to the next drive point
    task automatic read_csr(input logic [CSR_ADDR_W-1:0] addr, output logic [31:0] d1,
                            output logic [31:0] d2);
        rd1_en   = 1'b1;
        rd2_en   = 1'b1;
        rd1_addr = addr;
        rd2_addr = addr;
        #1;
        d1 = rd1_data;
        d2 = rd2_data;
        tick();
    endtask

    task automatic expect_csr(input string what, input logic [CSR_ADDR_W-1:0] addr,
                              input logic [31:0] exp);
        logic [31:0] d1;
        logic [31:0] d2;
        read_csr(addr, d1, d2);
        check_value({what, " port1"}, exp, d1);
        check_value({what, " port2"}, exp, d2);
    endtask

    task automatic take_exception(input exc_cause_e cause, input logic [31:0] pc,
                                  input logic [31:0] addr, input logic [5:0] ecode,
                                  input logic [8:0] esub, input logic inst);
        exc_valid    = 1'b1;
        exc_cause    = cause;
        exc_pc       = pc;
        exc_addr     = addr;
        exc_ecode    = ecode;
        exc_esubcode = esub;
        exc_inst     = inst;
        tick();
        exc_valid    = 1'b0;
    endtask

    task automatic return_from_exception();
        ertn = 1'b1;
        tick();
        ertn = 1'b0;
    endtask

    task automatic wait_timer_irq(input int limit);
        logic [31:0] d1;
        logic [31:0] d2;
        bit          seen;
        seen = 1'b0;
        for (int i = 0; i < limit && !seen; i++) begin
            read_csr(ESTAT, d1, d2);
            seen = d1[11];
        end
        if (!seen) begin
            $display("timeout: timer bit never showed in ESTAT within %0d cycles", limit);
            test_fails++;
            total_fails++;
        end
    endtask

    // badv_src 1 takes the pc, 2 the data address, 0 leaves BADV alone
    task automatic run_exception_case(input string label, input exc_cause_e cause,
                                      input logic inst, input logic [5:0] ecode,
                                      input logic [1:0] badv_src,
                                      input logic clash_era);
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] rnd;
        logic [31:0] d1;
        logic [31:0] d2;
        logic [31:0] badv_exp;
        write_csr(CRMD, 32'h17);  // plv 3, ie, pg
        read_csr(BADV, d1, d2);
        pc   = next_random();
        addr = next_random();
        rnd  = next_random();
        case (badv_src)
            2'd1:    badv_exp = pc;
            2'd2:    badv_exp = addr;
            default: badv_exp = d1;
        endcase
        if (clash_era) begin
            csr_we    = 1'b1;
            csr_waddr = ERA;
            csr_wdata = ~pc;
        end
        take_exception(cause, pc, addr, ecode, rnd[8:0], inst);
        csr_we = 1'b0;
        check_value({label, " era_o"}, pc, era);
        expect_csr({label, " ERA"}, ERA, pc);
        expect_csr({label, " PRMD"}, PRMD, 32'h7);
        expect_csr({label, " CRMD"}, CRMD, (cause == TLBR) ? 32'h08 : 32'h10);
        expect_csr({label, " BADV"}, BADV, badv_exp);
        read_csr(ESTAT, d1, d2);
        check_value({label, " ecode"}, {26'b0, ecode}, {26'b0, d1[21:16]});
        check_value({label, " esubcode"}, {23'b0, rnd[8:0]}, {23'b0, d2[30:22]});
    endtask

    // last resort if a loop misbehaves
    initial begin
        #500000;
        $display("simulation watchdog expired");
        $display("Errors found");
        $finish;
    end

    initial begin
        logic [31:0] data;
        logic [31:0] d1;
        logic [31:0] d2;
        int          sva_fails;

        clk          = 1'b0;
        rst          = 1'b1;
        csr_we       = 1'b0;
        csr_waddr    = CRMD;
        csr_wdata    = '0;
        rd1_en       = 1'b0;
        rd1_addr     = '0;
        rd2_en       = 1'b0;
        rd2_addr     = '0;
        exc_valid    = 1'b0;
        exc_cause    = INT;
        exc_pc       = '0;
        exc_addr     = '0;
        exc_ecode    = '0;
        exc_esubcode = '0;
        exc_inst     = 1'b0;
        ertn         = 1'b0;
        hwi          = '0;
        test_fails   = 0;
        total_fails  = 0;
        tests_run    = 0;
        checks_run   = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test("reset_and_read");
        reg_list = '{CRMD, PRMD, ECFG, ESTAT, ERA, BADV, EENTRY, SAVE0, SAVE1, SAVE2,
                     SAVE3, TID, TCFG, TVAL, TICLR};
        foreach (reg_list[i]) begin
            expect_csr(reg_list[i].name(), reg_list[i], (reg_list[i] == CRMD) ? 32'h8 : 32'h0);
        end
        rd1_en   = 1'b0;
        rd2_en   = 1'b0;
        rd1_addr = CRMD;
        rd2_addr = CRMD;
        #1;
        check_value("disabled port1", 32'h0, rd1_data);
        check_value("disabled port2", 32'h0, rd2_data);
        tick();
        expect_csr("unmapped", 14'h3ff, 32'h0);
        check_irq("irq after reset", 1'b0);
        finish_test();

        start_test("write_masks");
        mask_addr = '{CRMD, PRMD, ECFG, ESTAT, ERA, BADV, EENTRY, SAVE0, SAVE1, SAVE2,
                      SAVE3, TID};
        mask_val  = '{32'h0000_01ff, 32'h0000_0007, 32'h0000_1bff, 32'h0000_0003,
                      32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffc0, 32'hffff_ffff,
                      32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff};
        foreach (mask_addr[i]) begin
            data = next_random();
            write_csr(mask_addr[i], data);
            expect_csr(mask_addr[i].name(), mask_addr[i], data & mask_val[i]);
            if (mask_addr[i] == EENTRY) begin
                check_value("eentry_o", data & mask_val[i], eentry);
            end
        end
        write_csr(ECFG, 32'h0);
        write_csr(ESTAT, 32'h0);
        write_csr(CRMD, 32'h8);
        finish_test();

        start_test("exception_entry");
        run_exception_case("adef", ADEF, 1'b1, 6'h08, 2'd1, 1'b0);
        run_exception_case("ale", ALE, 1'b0, 6'h09, 2'd2, 1'b0);
        run_exception_case("pil", PIL, 1'b1, 6'h01, 2'd1, 1'b0);
        run_exception_case("sys", SYS, 1'b0, 6'h0b, 2'd0, 1'b1);  // with ERA write clash
        run_exception_case("tlbr", TLBR, 1'b0, 6'h3f, 2'd2, 1'b0);
        finish_test();

        start_test("exception_return");
        write_csr(CRMD, 32'h10);
        take_exception(SYS, next_random(), 32'h0, 6'h0b, 9'h0, 1'b0);
        write_csr(PRMD, 32'h5);
        return_from_exception();
        expect_csr("ertn plv ie", CRMD, 32'h15);
        write_csr(CRMD, 32'h17);
        take_exception(TLBR, next_random(), next_random(), 6'h3f, 9'h0, 1'b0);
        expect_csr("tlbr entry", CRMD, 32'h08);
        return_from_exception();
        expect_csr("tlbr ertn", CRMD, 32'h17);
        check_value("tlbr ertn crmd_o", 32'h17, crmd);
        finish_test();

        start_test("timer");
        write_csr(TCFG, 32'h0000_0021);  // one-shot
        expect_csr("tval load", TVAL, 32'h0000_0020);
        wait_timer_irq(80);
        expect_csr("tval one-shot end", TVAL, 32'hffff_ffff);
        write_csr(TICLR, 32'h1);
        read_csr(ESTAT, d1, d2);
        check_value("ti cleared", 32'h0, {31'b0, d1[11]});
        write_csr(TCFG, 32'h0000_000b);  // periodic, init 8
        wait_timer_irq(40);
        write_csr(TICLR, 32'h1);
        read_csr(ESTAT, d1, d2);
        check_value("ti cleared periodic", 32'h0, {31'b0, d1[11]});
        wait_timer_irq(40);  // back after reload
        write_csr(TCFG, 32'h0);
        write_csr(TICLR, 32'h1);
        finish_test();

        start_test("interrupt_request");
        write_csr(CRMD, 32'h4);
        write_csr(ECFG, 32'h0);
        hwi = 8'ha5;
        read_csr(ESTAT, d1, d2);
        check_value("hwi before sample", 32'h0, {24'b0, d1[9:2]});
        read_csr(ESTAT, d1, d2);
        check_value("hwi sampled", 32'h0000_00a5, {24'b0, d1[9:2]});
        check_irq("hwi no enable", 1'b0);
        write_csr(ECFG, 32'h4);
        check_irq("hwi0 enabled", 1'b1);
        write_csr(ECFG, 32'h8);
        check_irq("hwi1 idle line", 1'b0);
        write_csr(ECFG, 32'h4);
        take_exception(SYS, next_random(), 32'h0, 6'h0b, 9'h0, 1'b0);
        check_irq("ie cleared by exception", 1'b0);
        write_csr(CRMD, 32'h4);
        check_irq("ie set again", 1'b1);
        hwi = 8'h00;
        tick();
        check_irq("hwi dropped", 1'b0);
        write_csr(ESTAT, 32'h2);
        check_irq("swi1 not enabled", 1'b0);
        write_csr(ECFG, 32'h2);
        check_irq("swi1 enabled", 1'b1);
        write_csr(CRMD, 32'h0);
        check_irq("swi1 ie off", 1'b0);
        write_csr(CRMD, 32'h4);
        write_csr(ESTAT, 32'h0);
        check_irq("swi1 cleared", 1'b0);
        write_csr(ECFG, 32'h800);
        write_csr(TCFG, 32'h0000_0011);
        wait_timer_irq(60);
        check_irq("timer irq", 1'b1);
        write_csr(TICLR, 32'h1);
        check_irq("timer irq cleared", 1'b0);
        write_csr(TCFG, 32'h0);
        finish_test();

        sva_fails = uut.u_sva.fail_count;
        $display("tests %0d, checks %0d, failed checks %0d, assertion failures %0d",
                 tests_run, checks_run, total_fails, sva_fails);
        if (total_fails == 0 && sva_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- project.f
csr_pkg.sv
csr_trap_unit.sv
csr_timer.sv
csr_save_bank.sv
csr_read_mux.sv
csr_top.sv
csr_top_sva.sv
tb_csr_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_csr_top
FILELIST  := project.f
FLAGS     := --timing --assert
SIM_FLAGS := --binary -j 0
RUN_ARGS  := +verilator+error+limit+1000
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
